// ==== rv_core_pkg.sv ====
package rv_core_pkg;

	// Datapath widths
	localparam int DATA_W      = 32;	// Data word width
	localparam int REG_LOGSIZE = 5;	// Register index width
	localparam int REG_COUNT   = 32;	// Number of architectural registers
	localparam int SHAMT_W     = 5;	// Shift amount taken from operand b

	typedef logic [DATA_W-1:0]      word_t;	// Register data, immediates, results
	typedef logic [REG_LOGSIZE-1:0] reg_addr_t;	// Register index

	// Major opcodes accepted by the core
	localparam logic [6:0] OPC_OP     = 7'b0110011;	// Register-register ALU
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;	// Register-immediate ALU
	localparam logic [6:0] OPC_LUI    = 7'b0110111;	// Load upper immediate

	// funct3 encodings of the integer ALU group
	localparam logic [2:0] F3_ADD_SUB = 3'b000;	// ADD, SUB, ADDI
	localparam logic [2:0] F3_SLL     = 3'b001;	// Shift left logical
	localparam logic [2:0] F3_SLT     = 3'b010;	// Set less than, signed
	localparam logic [2:0] F3_SLTU    = 3'b011;	// Set less than, unsigned
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;	// Right shifts, split by funct7
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// Bit inside funct7 that selects SUB and SRA
	localparam int F7_ALT_BIT = 5;

	// ALU operation select
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		SLL    = 4'd2,
		SLT    = 4'd3,
		SLTU   = 4'd4,
		XOR    = 4'd5,
		SRL    = 4'd6,
		SRA    = 4'd7,
		OR     = 4'd8,
		AND    = 4'd9,
		PASS_B = 4'd10	// Operand b straight through, for LUI
	} alu_op_e;

endpackage

// ==== decode_if.sv ====
`timescale 1ns/100ps

// One decoded instruction on its way from decode to execute
interface decode_if;
	import rv_core_pkg::*;

	logic      valid;	// Single-cycle strobe, other fields qualified by it
	alu_op_e   alu_op;	// Operation for the ALU
	reg_addr_t rd;	// Destination register
	reg_addr_t rs1;	// Source register 1, for forwarding match
	reg_addr_t rs2;	// Source register 2, for forwarding match
	logic      use_rs1;	// rs1 is read by this instruction
	logic      use_rs2;	// rs2 is read by this instruction
	word_t     rs1_data;	// Register file data read at decode
	word_t     rs2_data;
	word_t     imm;	// I-type or U-type immediate
	logic      use_imm;	// Operand b comes from imm

	// Decoder side
	modport source (
		output valid, alu_op, rd, rs1, rs2, use_rs1, use_rs2,
		output rs1_data, rs2_data, imm, use_imm
	);

	// Execute side
	modport sink (
		input valid, alu_op, rd, rs1, rs2, use_rs1, use_rs2,
		input rs1_data, rs2_data, imm, use_imm
	);

endinterface

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
	input  logic                  clk,
	input  logic                  nrst,	// Synchronous reset, active low
	input  logic                  rd1_en,	// Port 1 read enable
	input  rv_core_pkg::reg_addr_t rd1_addr,	// Port 1 read address
	input  logic                  rd2_en,	// Port 2 read enable
	input  rv_core_pkg::reg_addr_t rd2_addr,	// Port 2 read address
	input  logic                  wr_en,	// Write enable
	input  rv_core_pkg::reg_addr_t wr_addr,	// Write address
	input  rv_core_pkg::word_t     wr_data,	// Write data
	output rv_core_pkg::word_t     rd_data1,	// Port 1 read data
	output rv_core_pkg::word_t     rd_data2	// Port 2 read data
);
	import rv_core_pkg::*;

	word_t regs [REG_COUNT];	// Flip-flop register array, regs[0] stays zero

	// One read port with write-through bypass
	function automatic word_t read_port(input logic en, input reg_addr_t addr);
		word_t data;
		if (!en)
			data = '0;	// Disabled port returns zero
		else if (wr_en && (wr_addr != '0) && (addr == wr_addr))
			data = wr_data;	// Same-cycle write seen by the read
		else
			data = regs[addr];
		return data;
	endfunction

	always_ff @(posedge clk) begin
		if (!nrst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;	// Whole array cleared
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;	// x0 never written
		end
	end

	// Combinational reads, same cycle as the address
	always_comb begin
		rd_data1 = read_port(rd1_en, rd1_addr);
		rd_data2 = read_port(rd2_en, rd2_addr);
	end

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   instr_valid,	// Instruction strobe
	input  rv_core_pkg::word_t     instr,	// Raw instruction word
	output logic                   rd1_en,	// Register file port 1
	output rv_core_pkg::reg_addr_t rd1_addr,
	output logic                   rd2_en,	// Register file port 2
	output rv_core_pkg::reg_addr_t rd2_addr,
	input  rv_core_pkg::word_t     rd_data1,	// Read data, same cycle
	input  rv_core_pkg::word_t     rd_data2,
	output logic                   illegal_instr,	// One cycle after a bad strobe
	decode_if.source               dec
);
	import rv_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rd;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	logic       f7_zero;	// funct7 all clear
	logic       f7_alt;	// funct7 with only the alternate bit
	alu_op_e    alu_op;
	logic       legal;
	logic       use_rs1;
	logic       use_rs2;
	logic       use_imm;
	word_t      imm;
	logic       accept;	// Legal instruction strobed this cycle

	// funct3 to operation, alt picks SUB or SRA
	function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			F3_ADD_SUB: op = alt ? SUB : ADD;
			F3_SLL:     op = SLL;
			F3_SLT:     op = SLT;
			F3_SLTU:    op = SLTU;
			F3_XOR:     op = XOR;
			F3_SRL_SRA: op = alt ? SRA : SRL;
			F3_OR:      op = OR;
			default:    op = AND;
		endcase
		return op;
	endfunction

	// Field split
	assign opcode  = instr[6:0];
	assign rd      = instr[11:7];
	assign funct3  = instr[14:12];
	assign rs1     = instr[19:15];
	assign rs2     = instr[24:20];
	assign funct7  = instr[31:25];
	assign f7_zero = (funct7 == 7'b0);
	assign f7_alt  = (funct7 == (7'b1 << F7_ALT_BIT));

	always_comb begin
		alu_op  = ADD;
		legal   = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_imm = 1'b0;
		imm     = '0;
		case (opcode)
			OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				alu_op  = f3_op(funct3, funct7[F7_ALT_BIT]);
				// Alternate funct7 only for SUB and SRA
				legal   = f7_zero ||
					(f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
			end
			OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				use_imm = 1'b1;
				imm     = {{(DATA_W-12){instr[31]}}, instr[31:20]};	// Sign-extended I-imm
				alu_op  = f3_op(funct3, (funct3 == F3_SRL_SRA) && funct7[F7_ALT_BIT]);
				if (funct3 == F3_SLL)
					legal = f7_zero;	// SLLI has no alternate form
				else if (funct3 == F3_SRL_SRA)
					legal = f7_zero || f7_alt;
				else
					legal = 1'b1;
			end
			OPC_LUI: begin
				use_imm = 1'b1;
				imm     = {instr[31:12], 12'b0};	// U-imm in the upper 20 bits
				alu_op  = PASS_B;
				legal   = 1'b1;
			end
			default: legal = 1'b0;	// Anything else is flagged
		endcase
	end

	assign accept = instr_valid && legal;

	// Only the ports the instruction needs
	assign rd1_en   = accept && use_rs1;
	assign rd1_addr = rs1;
	assign rd2_en   = accept && use_rs2;
	assign rd2_addr = rs2;

	// Control state
	always_ff @(posedge clk) begin
		if (!nrst) begin
			dec.valid     <= 1'b0;
			illegal_instr <= 1'b0;
		end else begin
			dec.valid     <= accept;
			illegal_instr <= instr_valid && !legal;
		end
	end

	// Decoded payload with read data
	always_ff @(posedge clk) begin
		if (accept) begin
			dec.alu_op   <= alu_op;
			dec.rd       <= rd;
			dec.rs1      <= rs1;
			dec.rs2      <= rs2;
			dec.use_rs1  <= use_rs1;
			dec.use_rs2  <= use_rs2;
			dec.rs1_data <= rd_data1;
			dec.rs2_data <= rd_data2;
			dec.imm      <= imm;
			dec.use_imm  <= use_imm;
		end
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu (
	input  rv_core_pkg::alu_op_e op,	// Operation select
	input  rv_core_pkg::word_t   a,	// Operand a, rs1
	input  rv_core_pkg::word_t   b,	// Operand b, rs2 or immediate
	output rv_core_pkg::word_t   result
);
	import rv_core_pkg::*;

	logic [SHAMT_W-1:0] shamt;	// Low bits of b
	logic               lt_signed;
	logic               lt_unsigned;

	assign shamt       = b[SHAMT_W-1:0];
	assign lt_signed   = ($signed(a) < $signed(b));
	assign lt_unsigned = (a < b);

	always_comb begin
		case (op)
			ADD:     result = a + b;
			SUB:     result = a - b;
			SLL:     result = a << shamt;
			SLT:     result = {{(DATA_W-1){1'b0}}, lt_signed};	// 0 or 1
			SLTU:    result = {{(DATA_W-1){1'b0}}, lt_unsigned};
			XOR:     result = a ^ b;
			SRL:     result = a >> shamt;	// Zero fill
			SRA:     result = word_t'($signed(a) >>> shamt);	// Sign fill
			OR:      result = a | b;
			AND:     result = a & b;
			PASS_B:  result = b;	// LUI
			default: result = '0;
		endcase
	end

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage (
	input  logic                   clk,
	input  logic                   nrst,
	decode_if.sink                 dec,	// Decoded instruction from decode
	output logic                   wb_valid,	// Write-back strobe
	output rv_core_pkg::reg_addr_t wb_rd,	// Write-back destination
	output rv_core_pkg::word_t     wb_data	// Write-back result
);
	import rv_core_pkg::*;

	logic  fwd1;	// rs1 taken from write-back
	logic  fwd2;	// rs2 taken from write-back
	logic  wb_live;	// Write-back holds a real nonzero destination
	word_t rs1_val;
	word_t rs2_val;
	word_t op_a;
	word_t op_b;
	word_t alu_result;

	// Result of the previous instruction, still one cycle from the register file
	assign wb_live = wb_valid && (wb_rd != '0);
	assign fwd1    = dec.use_rs1 && wb_live && (wb_rd == dec.rs1);
	assign fwd2    = dec.use_rs2 && wb_live && (wb_rd == dec.rs2);

	assign rs1_val = fwd1 ? wb_data : dec.rs1_data;
	assign rs2_val = fwd2 ? wb_data : dec.rs2_data;

	// Operand selection
	assign op_a = rs1_val;
	assign op_b = dec.use_imm ? dec.imm : rs2_val;	// Immediate overrides rs2

	alu u_alu (
		.op     (dec.alu_op),
		.a      (op_a),
		.b      (op_b),
		.result (alu_result)
	);

	// Write-back strobe
	always_ff @(posedge clk) begin
		if (!nrst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= dec.valid;	// One cycle behind decode
		end
	end

	// Write-back payload, also the register file write port
	always_ff @(posedge clk) begin
		if (dec.valid) begin
			wb_rd   <= dec.rd;
			wb_data <= alu_result;
		end
	end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
	input  logic                   clk,
	input  logic                   nrst,	// Synchronous reset, active low
	input  logic                   instr_valid,	// One instruction per strobe
	input  rv_core_pkg::word_t     instr,
	output logic                   wb_valid,	// Two cycles after a legal strobe
	output rv_core_pkg::reg_addr_t wb_rd,
	output rv_core_pkg::word_t     wb_data,
	output logic                   illegal_instr	// One cycle after a bad strobe
);
	import rv_core_pkg::*;

	// Register file read side
	logic      rd1_en;
	reg_addr_t rd1_addr;
	logic      rd2_en;
	reg_addr_t rd2_addr;
	word_t     rd_data1;
	word_t     rd_data2;

	decode_if dec_bus ();	// Decode to execute

	instr_decoder u_decoder (
		.clk           (clk),
		.nrst          (nrst),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.rd1_en        (rd1_en),
		.rd1_addr      (rd1_addr),
		.rd2_en        (rd2_en),
		.rd2_addr      (rd2_addr),
		.rd_data1      (rd_data1),
		.rd_data2      (rd_data2),
		.illegal_instr (illegal_instr),
		.dec           (dec_bus.source)
	);

	// Write port fed straight from the write-back register
	reg_file u_reg_file (
		.clk      (clk),
		.nrst     (nrst),
		.rd1_en   (rd1_en),
		.rd1_addr (rd1_addr),
		.rd2_en   (rd2_en),
		.rd2_addr (rd2_addr),
		.wr_en    (wb_valid),
		.wr_addr  (wb_rd),
		.wr_data  (wb_data),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	exec_stage u_exec (
		.clk      (clk),
		.nrst     (nrst),
		.dec      (dec_bus.sink),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

endmodule

// ==== rv_core_checker.sv ====
`timescale 1ns/100ps

module rv_core_checker (
	input logic clk,
	input logic nrst,
	input logic instr_valid,
	input logic wb_valid,
	input logic illegal_instr
);

	// Legal strobe reaches write-back exactly two edges later
	a_wb_latency: assert property (@(posedge clk) disable iff (!nrst)
		instr_valid ##1 !illegal_instr |=> wb_valid)
		else $error("write-back missing two cycles after a legal instruction");

	// No write-back without a legal strobe two cycles before
	a_wb_source: assert property (@(posedge clk) disable iff (!nrst)
		wb_valid |-> $past(instr_valid, 2) && !$past(illegal_instr))
		else $error("write-back without a matching legal instruction");

	// Illegal flag one cycle after its strobe
	a_illegal_latency: assert property (@(posedge clk) disable iff (!nrst)
		illegal_instr |-> $past(instr_valid))
		else $error("illegal_instr without a strobe one cycle before");

	a_reset_outputs: assert property (@(posedge clk)
		!nrst |=> !wb_valid && !illegal_instr)
		else $error("outputs not cleared by reset");

endmodule

// ==== rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;
	import rv_core_pkg::*;

	localparam int SEED       = 37079;
	localparam int N_RANDOM   = 400;	// Random instructions after the directed part
	localparam int DRAIN_WAIT = 20;	// Cycles allowed for the pipeline to empty

	logic      clk;
	logic      nrst;
	logic      instr_valid;
	word_t     instr;
	logic      wb_valid;
	reg_addr_t wb_rd;
	word_t     wb_data;
	logic      illegal_instr;

	word_t     model_regs [REG_COUNT];	// Architectural state of the reference
	logic      exp_legal_q [$];	// One entry per strobed instruction in issue order
	reg_addr_t exp_rd_q [$];
	word_t     exp_data_q [$];

	rv_core uut (
		.clk           (clk),
		.nrst          (nrst),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.illegal_instr (illegal_instr)
	);

	bind rv_core rv_core_checker u_checker (
		.clk           (clk),
		.nrst          (nrst),
		.instr_valid   (instr_valid),
		.wb_valid      (wb_valid),
		.illegal_instr (illegal_instr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	// Instruction encoders
	function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
		return {imm, rd, OPC_LUI};
	endfunction

	// ISA model that updates model_regs and returns 1 for a legal instruction
	function automatic logic ref_exec(input word_t ins, output reg_addr_t rd,
		output word_t data);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic       alt;
		logic       legal;
		word_t      a;
		word_t      b;
		logic [4:0] sh;
		opc  = ins[6:0];
		f3   = ins[14:12];
		f7   = ins[31:25];
		rd   = ins[11:7];
		a    = model_regs[ins[19:15]];
		b    = (opc == OPC_OP) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
		sh   = b[4:0];
		alt  = f7[F7_ALT_BIT] && (opc == OPC_OP || f3 == F3_SRL_SRA);	// ADDI etc ignore it
		data = '0;
		if (opc == OPC_OP)	// Alternate funct7 only on SUB and SRA
			legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
		else if (opc == OPC_OP_IMM)
			legal = (f3 == F3_SLL) ? (f7 == 7'h00) :
				(f3 != F3_SRL_SRA || f7 == 7'h00 || f7 == 7'h20);
		else
			legal = (opc == OPC_LUI);
		if (opc == OPC_LUI) begin
			data = {ins[31:12], 12'h000};	// Upper 20 bits
		end else begin
			case (f3)
				F3_ADD_SUB: data = alt ? a - b : a + b;
				F3_SLL:     data = a << sh;
				F3_SLT:     data = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
				F3_SLTU:    data = {31'b0, a < b};
				F3_XOR:     data = a ^ b;
				F3_SRL_SRA: data = (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
				F3_OR:      data = a | b;
				default:    data = a & b;
			endcase
		end
		if (legal && rd != 0)
			model_regs[rd] = data;	// x0 stays zero
		return legal;
	endfunction

	// Weighted mix on x0..x7 so hazards are frequent
	function automatic word_t random_instr();
		int unsigned pick;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		pick = $urandom_range(99);
		rd   = reg_addr_t'($urandom_range(7));
		rs1  = reg_addr_t'($urandom_range(7));
		rs2  = reg_addr_t'($urandom_range(7));
		f3   = 3'($urandom_range(7));
		imm  = 12'($urandom);
		if (pick < 45) begin
			f7 = ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $urandom_range(1)) ? 7'h20 : 7'h00;
			return r_type(f7, rs2, rs1, f3, rd);
		end else if (pick < 80) begin
			if (f3 == F3_SLL)
				imm[11:5] = 7'h00;
			else if (f3 == F3_SRL_SRA)
				imm[11:5] = $urandom_range(1) ? 7'h20 : 7'h00;	// SRAI or SRLI
			return i_type(imm, rs1, f3, rd);
		end else if (pick < 92) begin
			return u_type(20'($urandom), rd);
		end
		case ($urandom_range(2))
			0:       return {25'($urandom_range(32'h1FF_FFFF)), 7'b0000011};	// Unsupported load
			1:       return r_type(7'h01, rs2, rs1, f3, rd);	// Multiply group
			default: return i_type({7'h20, 5'd3}, rs1, F3_SLL, rd);	// SLLI with bad funct7
		endcase
	endfunction

	task automatic send(input word_t ins);
		reg_addr_t rd;
		word_t     data;
		logic      legal;
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= ins;
		legal = ref_exec(ins, rd, data);
		exp_legal_q.push_back(legal);
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(data);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			instr       <= '0;
		end
	endtask

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_wb(input logic exp_legal, input reg_addr_t exp_rd,
		input word_t exp_data, input reg_addr_t got_rd, input word_t got_data);
		if (!exp_legal)
			report_fail($sformatf("Mismatch at %0t: write-back for an illegal instruction",
				$time));
		else if (got_rd !== exp_rd || got_data !== exp_data)
			report_fail($sformatf("Mismatch at %0t: got x%0d = %h, expected x%0d = %h",
				$time, got_rd, got_data, exp_rd, exp_data));
	endtask

	task automatic check_illegal(input logic exp_legal);
		if (exp_legal)
			report_fail($sformatf("Mismatch at %0t: illegal_instr for a legal instruction",
				$time));
	endtask

	// Older instruction always reaches write-back first when both fire
	always @(negedge clk) begin
		if (nrst) begin
			if (wb_valid) begin
				if (exp_legal_q.size() == 0)
					report_fail("Write-back seen with no instruction outstanding");
				else
					check_wb(exp_legal_q.pop_front(), exp_rd_q.pop_front(),
						exp_data_q.pop_front(), wb_rd, wb_data);
			end
			if (illegal_instr) begin
				if (exp_legal_q.size() == 0)
					report_fail("illegal_instr raised with no instruction outstanding");
				else begin
					void'(exp_rd_q.pop_front());
					void'(exp_data_q.pop_front());
					check_illegal(exp_legal_q.pop_front());
				end
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		nrst        = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		for (int k = 0; k < REG_COUNT; k++)
			model_regs[k] = '0;
		repeat (4) @(posedge clk);
		nrst <= 1'b1;
		for (int k = 0; k < REG_COUNT; k++)
			send(i_type(12'h000, reg_addr_t'(k), F3_ADD_SUB, reg_addr_t'(k)));	// ADDI xk, xk, 0 reads zero
		send(u_type(20'hFFFFF, 5'd1));	// x1 negative
		send(i_type(12'd13, 5'd0, F3_ADD_SUB, 5'd2));
		for (int f = 0; f < 8; f++)
			send(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
		send(r_type(7'h20, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));	// SUB
		send(r_type(7'h20, 5'd2, 5'd1, F3_SRL_SRA, 5'd3));	// SRA keeps sign
		for (int f = 0; f < 8; f++)
			send(i_type((f == 1 || f == 5) ? 12'h004 : 12'h805, 5'd1, 3'(f), 5'd4));
		send(i_type(12'h404, 5'd1, F3_SRL_SRA, 5'd4));	// SRAI
		send(i_type(12'h001, 5'd1, F3_ADD_SUB, 5'd5));	// Dependency chain
		send(r_type(7'h00, 5'd5, 5'd5, F3_ADD_SUB, 5'd6));
		send(r_type(7'h20, 5'd5, 5'd6, F3_ADD_SUB, 5'd7));
		send(r_type(7'h00, 5'd6, 5'd7, F3_XOR, 5'd5));
		send(i_type(12'h005, 5'd1, F3_ADD_SUB, 5'd0));	// Write to x0 is dropped
		send(r_type(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd8));
		send(32'h0000_0003);	// Load opcode
		send(r_type(7'h00, 5'd1, 5'd0, F3_OR, 5'd8));
		idle(2);
		for (int i = 0; i < N_RANDOM; i++) begin
			send(random_instr());
			if ($urandom_range(7) == 0)
				idle(1 + $urandom_range(2));
		end
		idle(1);
		for (int t = 0; t < DRAIN_WAIT && exp_legal_q.size() != 0; t++)
			@(posedge clk);
		repeat (2) @(posedge clk);	// Catch stray outputs
		if (exp_legal_q.size() != 0)
			report_fail("Timed out with results still outstanding");
		else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// ==== rv_core.f ====
rv_core_pkg.sv
decode_if.sv
reg_file.sv
instr_decoder.sv
alu.sv
exec_stage.sv
rv_core.sv
rv_core_checker.sv
rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - rv_core_pkg.sv
      - decode_if.sv
      - reg_file.sv
      - instr_decoder.sv
      - alu.sv
      - exec_stage.sv
      - rv_core.sv
  - target: simulation
    files:
      - rv_core_checker.sv
      - rv_core_tb.sv
